// File: hw/stream_buffer_defines.svh
`ifndef STREAM_BUFFER_DEFINES_SVH
`define STREAM_BUFFER_DEFINES_SVH

// Feature word width.
`define SB_DATA_W 16

// Bank address width.
`define SB_ADDR_W 14

// Reads per channel group.
`define SB_LANES 4

// Address to data latency through a bank.
`define SB_RD_LAT 3

// Count register width.
`define SB_CNT_W 10

`endif

// File: hw/stream_buffer_pkg.sv
`default_nettype none

`include "stream_buffer_defines.svh"

package stream_buffer_pkg;

	typedef logic [`SB_DATA_W-1:0] feature_t;
	typedef logic [`SB_ADDR_W-1:0] buf_addr_t;
	typedef logic [`SB_CNT_W-1:0]  count_t;
	typedef logic [1:0]            cfg_addr_t;

	// Geometry register map. Index 3 is unused.
	localparam cfg_addr_t CFG_CHANS  = 2'd0;
	localparam cfg_addr_t CFG_WIDTHS = 2'd1;
	localparam cfg_addr_t CFG_STRIDE = 2'd2;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_e;

endpackage

`default_nettype wire

// File: hw/feature_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_defines.svh"

module feature_ram (
	input  wire                           clk,
	input  wire                           i_wen,
	input  wire stream_buffer_pkg::buf_addr_t i_waddr,
	input  wire stream_buffer_pkg::buf_addr_t i_raddr,
	input  wire stream_buffer_pkg::feature_t  i_wdata,
	output stream_buffer_pkg::feature_t       o_rdata
);
	import stream_buffer_pkg::*;

	localparam int DEPTH = 2 ** `SB_ADDR_W;

	feature_t  mem [DEPTH];
	buf_addr_t raddr_q;
	feature_t  array_q;
	feature_t  pipe_q;

	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Address, array and output stages.
	// Same-address write in the same cycle reads the old word.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		array_q <= mem[raddr_q];
		pipe_q  <= array_q;
	end

	assign o_rdata = pipe_q;

endmodule

`default_nettype wire

// File: hw/scan_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scan_config_regs (
	input  wire                            clk,
	input  wire                            i_reset,
	input  wire                            i_cfg_wen,
	input  wire stream_buffer_pkg::cfg_addr_t i_cfg_addr,
	input  wire stream_buffer_pkg::count_t    i_cfg_wdata,
	output stream_buffer_pkg::count_t         o_cfg_rdata,
	output stream_buffer_pkg::count_t         o_chans,
	output stream_buffer_pkg::count_t         o_widths,
	output stream_buffer_pkg::count_t         o_stride
);
	import stream_buffer_pkg::*;

	count_t chans_q;
	count_t widths_q;
	count_t stride_q;
	count_t wdata_nz;

	// Zero counts become one.
	assign wdata_nz = (i_cfg_wdata == '0) ? count_t'(1) : i_cfg_wdata;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			chans_q  <= count_t'(1);
			widths_q <= count_t'(1);
			stride_q <= count_t'(4);
		end else if (i_cfg_wen) begin
			case (i_cfg_addr)
				CFG_CHANS:  chans_q  <= wdata_nz;
				CFG_WIDTHS: widths_q <= wdata_nz;
				CFG_STRIDE: stride_q <= i_cfg_wdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (i_cfg_addr)
			CFG_CHANS:  o_cfg_rdata = chans_q;
			CFG_WIDTHS: o_cfg_rdata = widths_q;
			CFG_STRIDE: o_cfg_rdata = stride_q;
			default:    o_cfg_rdata = '0;
		endcase
	end

	assign o_chans  = chans_q;
	assign o_widths = widths_q;
	assign o_stride = stride_q;

	a_counts_nonzero: assert property (@(posedge clk) disable iff (i_reset)
		(chans_q != '0) && (widths_q != '0));

endmodule

`default_nettype wire

// File: hw/window_read_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_defines.svh"

module window_read_sequencer (
	input  wire                         clk,
	input  wire                         i_reset,
	input  wire                         i_start,
	input  wire stream_buffer_pkg::count_t i_chans,
	input  wire stream_buffer_pkg::count_t i_widths,
	input  wire stream_buffer_pkg::count_t i_stride,
	output stream_buffer_pkg::buf_addr_t   o_raddr,
	output logic                           o_valid,
	output logic                           o_done
);
	import stream_buffer_pkg::*;

	localparam int LANE_W = $clog2(`SB_LANES);
	localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(`SB_LANES - 1);

	seq_state_e state_q;
	logic [LANE_W-1:0] lane_q;
	count_t    chan_q;
	count_t    width_q;
	count_t    chans_q;
	count_t    widths_q;
	count_t    stride_q;
	buf_addr_t base_q;
	buf_addr_t row_q;
	buf_addr_t next_row;
	logic      launch;
	logic      issue;
	logic      chan_last;
	logic      width_last;
	logic      last;
	logic [`SB_RD_LAT-1:0] valid_pipe_q;
	logic [`SB_RD_LAT-1:0] done_pipe_q;

	assign launch     = (state_q == SEQ_IDLE) && i_start;
	assign issue      = (state_q == SEQ_RUN);
	assign chan_last  = (chan_q == count_t'(chans_q - 1'b1));
	assign width_last = (width_q == count_t'(widths_q - 1'b1));
	assign last       = issue && (lane_q == LANE_LAST) && chan_last && width_last;
	assign next_row   = row_q + buf_addr_t'(stride_q);

	// Geometry is frozen for the whole sweep.
	always_ff @(posedge clk) begin
		if (launch) begin
			chans_q  <= i_chans;
			widths_q <= i_widths;
			stride_q <= i_stride;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state_q <= SEQ_IDLE;
			lane_q  <= '0;
			chan_q  <= '0;
			width_q <= '0;
			base_q  <= '0;
			row_q   <= '0;
		end else if (launch) begin
			state_q <= SEQ_RUN;
			lane_q  <= '0;
			chan_q  <= '0;
			width_q <= '0;
			base_q  <= '0;
			row_q   <= '0;
		end else if (issue) begin
			if (lane_q != LANE_LAST) begin
				lane_q <= lane_q + 1'b1;
			end else begin
				lane_q <= '0;
				if (!chan_last) begin
					chan_q <= chan_q + 1'b1;
					base_q <= base_q + 1'b1;
				end else begin
					chan_q <= '0;
					if (width_last) begin
						state_q <= SEQ_IDLE;
					end else begin
						// Next row starts one stride further on.
						width_q <= width_q + 1'b1;
						row_q   <= next_row;
						base_q  <= next_row;
					end
				end
			end
		end
	end

	assign o_raddr = base_q + buf_addr_t'(lane_q);

	// Match the bank read latency.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_pipe_q <= '0;
			done_pipe_q  <= '0;
		end else begin
			valid_pipe_q <= {valid_pipe_q[`SB_RD_LAT-2:0], issue};
			done_pipe_q  <= {done_pipe_q[`SB_RD_LAT-2:0], last};
		end
	end

	assign o_valid = valid_pipe_q[`SB_RD_LAT-1];
	assign o_done  = done_pipe_q[`SB_RD_LAT-1];

	a_done_valid: assert property (@(posedge clk) disable iff (i_reset)
		o_done |-> o_valid);

	a_lane_range: assert property (@(posedge clk) disable iff (i_reset)
		lane_q < `SB_LANES);

endmodule

`default_nettype wire

// File: hw/stream_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer (
	input  wire                            clk,
	input  wire                            i_reset,
	input  wire                            i_cfg_wen,
	input  wire stream_buffer_pkg::cfg_addr_t i_cfg_addr,
	input  wire stream_buffer_pkg::count_t    i_cfg_wdata,
	output wire stream_buffer_pkg::count_t    o_cfg_rdata,
	input  wire                            i_start,
	input  wire                            i_wen0,
	input  wire stream_buffer_pkg::buf_addr_t i_ddr_waddr,
	input  wire stream_buffer_pkg::feature_t  i_ddr,
	input  wire                            i_wen1,
	input  wire stream_buffer_pkg::buf_addr_t i_waddr,
	input  wire stream_buffer_pkg::feature_t  i_pool,
	input  wire stream_buffer_pkg::feature_t  i_eltwise,
	input  wire                            i_eltwise_sel,
	output wire stream_buffer_pkg::feature_t  o_feature_0,
	output wire stream_buffer_pkg::feature_t  o_feature_1,
	output wire                            o_valid,
	output wire                            o_done
);
	import stream_buffer_pkg::*;

	count_t    chans;
	count_t    widths;
	count_t    stride;
	buf_addr_t rd_addr;
	feature_t  bank1_wdata;

	scan_config_regs u_cfg (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_cfg_wen   (i_cfg_wen),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg_rdata (o_cfg_rdata),
		.o_chans     (chans),
		.o_widths    (widths),
		.o_stride    (stride)
	);

	window_read_sequencer u_seq (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_start  (i_start),
		.i_chans  (chans),
		.i_widths (widths),
		.i_stride (stride),
		.o_raddr  (rd_addr),
		.o_valid  (o_valid),
		.o_done   (o_done)
	);

	// Bank 1 source select.
	assign bank1_wdata = i_eltwise_sel ? i_eltwise : i_pool;

	feature_ram u_bank0 (
		.clk     (clk),
		.i_wen   (i_wen0),
		.i_waddr (i_ddr_waddr),
		.i_raddr (rd_addr),
		.i_wdata (i_ddr),
		.o_rdata (o_feature_0)
	);

	feature_ram u_bank1 (
		.clk     (clk),
		.i_wen   (i_wen1),
		.i_waddr (i_waddr),
		.i_raddr (rd_addr),
		.i_wdata (bank1_wdata),
		.o_rdata (o_feature_1)
	);

endmodule

`default_nettype wire

// File: dv/stream_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_defines.svh"

module stream_buffer_tb;
	import stream_buffer_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam int DEPTH    = 2 ** `SB_ADDR_W;
	localparam int PERIOD   = 10;

	logic      clk = 1'b0;
	logic      i_reset;
	logic      i_cfg_wen;
	cfg_addr_t i_cfg_addr;
	count_t    i_cfg_wdata;
	count_t    o_cfg_rdata;
	logic      i_start;
	logic      i_wen0;
	buf_addr_t i_ddr_waddr;
	feature_t  i_ddr;
	logic      i_wen1;
	buf_addr_t i_waddr;
	feature_t  i_pool;
	feature_t  i_eltwise;
	logic      i_eltwise_sel;
	feature_t  o_feature_0;
	feature_t  o_feature_1;
	logic      o_valid;
	logic      o_done;

	// One column per sweep field. A zero chans is stored as one.
	int    row_chans  [NUM_ROWS] = '{1, 2, 0, 3, 4, 2};
	int    row_widths [NUM_ROWS] = '{1, 3, 2, 2, 5, 2};
	int    row_stride [NUM_ROWS] = '{4, 4, 5, 1, 8, 0};
	logic  row_sel    [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
	string row_name   [NUM_ROWS] = '{"defaults", "two_by_three", "zero_chans",
		"overlap", "wide", "stride_zero"};

	feature_t  shadow0 [DEPTH];
	feature_t  shadow1 [DEPTH];
	buf_addr_t exp_addr [$];
	int        errors = 0;
	int        checks = 0;
	int        cyc = 0;
	int        start_cyc = 0;
	int        seen = 0;
	int        done_cnt = 0;
	int        sweep_len = 0;
	bit        started = 1'b0;
	string     test_name = "reset";

	stream_buffer i_dut (.*);

	initial begin
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic int eff_count(input int raw);
		return (raw == 0) ? 1 : raw;
	endfunction

	function automatic int sweep_beats(input int r);
		return eff_count(row_chans[r]) * eff_count(row_widths[r]) * `SB_LANES;
	endfunction

	// Number of addresses a sweep can touch.
	function automatic int span(input int r);
		int top;
		top = (eff_count(row_widths[r]) - 1) * row_stride[r];
		top = top + eff_count(row_chans[r]) - 1 + `SB_LANES - 1;
		return top + 1;
	endfunction

	task automatic compare(input string what, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	// Sets every control input for the coming cycle.
	task automatic cfg_cycle(input logic wen, input cfg_addr_t a, input count_t d,
		input logic start);
		@(posedge clk);
		#1;
		i_cfg_wen   = wen;
		i_cfg_addr  = a;
		i_cfg_wdata = d;
		i_start     = start;
	endtask

	task automatic check_cfg(input cfg_addr_t a, input int exp, input string what);
		cfg_cycle(1'b0, a, '0, 1'b0);
		@(negedge clk);
		compare(what, exp, int'(o_cfg_rdata));
	endtask

	task automatic preload(input int r);
		feature_t ddr;
		feature_t pool;
		feature_t elt;
		for (int a = 0; a < span(r); a++) begin
			ddr  = feature_t'($urandom);
			pool = feature_t'($urandom);
			elt  = feature_t'($urandom);
			@(posedge clk);
			#1;
			i_wen0        = 1'b1;
			i_ddr_waddr   = buf_addr_t'(a);
			i_ddr         = ddr;
			i_wen1        = 1'b1;
			i_waddr       = buf_addr_t'(a);
			i_pool        = pool;
			i_eltwise     = elt;
			i_eltwise_sel = row_sel[r];
			shadow0[a] = ddr;
			shadow1[a] = row_sel[r] ? elt : pool;
		end
		@(posedge clk);
		#1;
		i_wen0 = 1'b0;
		i_wen1 = 1'b0;
	endtask

	// Lane fastest, then channel group, then width step.
	task automatic build_expected(input int r);
		exp_addr.delete();
		for (int w = 0; w < eff_count(row_widths[r]); w++) begin
			for (int c = 0; c < eff_count(row_chans[r]); c++) begin
				for (int l = 0; l < `SB_LANES; l++) begin
					exp_addr.push_back(buf_addr_t'((w * row_stride[r] + c + l) % DEPTH));
				end
			end
		end
		seen      = 0;
		done_cnt  = 0;
		sweep_len = sweep_beats(r);
	endtask

	task automatic run_sweep(input int nxt);
		int waited;
		started = 1'b1;
		cfg_cycle(1'b0, CFG_CHANS, '0, 1'b1);
		start_cyc = cyc;
		// Next row's geometry is written while this sweep runs.
		cfg_cycle(1'b1, CFG_CHANS, count_t'(row_chans[nxt]), 1'b0);
		cfg_cycle(1'b1, CFG_WIDTHS, count_t'(row_widths[nxt]), 1'b0);
		cfg_cycle(1'b1, CFG_STRIDE, count_t'(row_stride[nxt]), 1'b0);
		// Restart request while busy.
		cfg_cycle(1'b0, CFG_CHANS, '0, 1'b1);
		cfg_cycle(1'b0, CFG_CHANS, '0, 1'b0);
		waited = 0;
		while (done_cnt == 0 && waited < sweep_len + 20) begin
			@(posedge clk);
			waited++;
		end
		assert (done_cnt != 0) else begin
			errors++;
			$display("%s: o_done never arrived within the expected time", test_name);
		end
		repeat (8) @(posedge clk);
		compare("valid beats", sweep_len, seen);
		compare("done pulses", 1, done_cnt);
	endtask

	always @(negedge clk) begin : monitor
		buf_addr_t addr;
		if (!started) begin
			assert (!o_valid && !o_done) else begin
				errors++;
				$display("%s: o_valid or o_done high before the first start", test_name);
			end
		end else if (o_valid) begin
			assert (exp_addr.size() != 0) else begin
				errors++;
				$display("%s: o_valid high with no sweep data expected", test_name);
			end
			if (exp_addr.size() != 0) begin
				addr = exp_addr.pop_front();
				compare("beat cycle", start_cyc + 1 + `SB_RD_LAT + seen, cyc);
				compare("o_feature_0", int'(shadow0[addr]), int'(o_feature_0));
				compare("o_feature_1", int'(shadow1[addr]), int'(o_feature_1));
				seen++;
				if (o_done) begin
					done_cnt++;
					compare("done beat", sweep_len, seen);
				end
			end
		end else begin
			assert (!o_done) else begin
				errors++;
				$display("%s: o_done high while o_valid is low", test_name);
			end
		end
	end

	initial begin : watchdog
		int limit;
		limit = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += span(r) + sweep_beats(r) + 20;
		end
		repeat (limit * 2) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit * 2);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		int nxt;
		void'($urandom(32'h3469e393));
		i_reset       = 1'b1;
		i_cfg_wen     = 1'b0;
		i_cfg_addr    = '0;
		i_cfg_wdata   = '0;
		i_start       = 1'b0;
		i_wen0        = 1'b0;
		i_ddr_waddr   = '0;
		i_ddr         = '0;
		i_wen1        = 1'b0;
		i_waddr       = '0;
		i_pool        = '0;
		i_eltwise     = '0;
		i_eltwise_sel = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		i_reset = 1'b0;

		test_name = "reset_defaults";
		check_cfg(CFG_CHANS, 1, "chans");
		check_cfg(CFG_WIDTHS, 1, "widths");
		check_cfg(CFG_STRIDE, 4, "stride");
		check_cfg(2'd3, 0, "unused index");

		test_name = "cfg_readback";
		cfg_cycle(1'b1, CFG_CHANS, 10'd7, 1'b0);
		check_cfg(CFG_CHANS, 7, "chans");
		cfg_cycle(1'b1, CFG_WIDTHS, 10'd9, 1'b0);
		check_cfg(CFG_WIDTHS, 9, "widths");
		cfg_cycle(1'b1, CFG_STRIDE, 10'd300, 1'b0);
		check_cfg(CFG_STRIDE, 300, "stride");
		cfg_cycle(1'b1, 2'd3, 10'd5, 1'b0);
		check_cfg(2'd3, 0, "unused index");
		cfg_cycle(1'b1, CFG_CHANS, 10'd0, 1'b0);
		check_cfg(CFG_CHANS, 1, "zero chans");
		cfg_cycle(1'b1, CFG_WIDTHS, 10'd0, 1'b0);
		check_cfg(CFG_WIDTHS, 1, "zero widths");

		// Later rows get their geometry during the sweep before.
		cfg_cycle(1'b1, CFG_CHANS, count_t'(row_chans[0]), 1'b0);
		cfg_cycle(1'b1, CFG_WIDTHS, count_t'(row_widths[0]), 1'b0);
		cfg_cycle(1'b1, CFG_STRIDE, count_t'(row_stride[0]), 1'b0);
		cfg_cycle(1'b0, CFG_CHANS, '0, 1'b0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			test_name = row_name[r];
			nxt = (r + 1) % NUM_ROWS;
			preload(r);
			check_cfg(CFG_CHANS, eff_count(row_chans[r]), "chans");
			check_cfg(CFG_WIDTHS, eff_count(row_widths[r]), "widths");
			check_cfg(CFG_STRIDE, row_stride[r], "stride");
			build_expected(r);
			run_sweep(nxt);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/stream_buffer_pkg.sv
hw/feature_ram.sv
hw/scan_config_regs.sv
hw/window_read_sequencer.sv
hw/stream_buffer.sv
dv/stream_buffer_tb.sv

// File: Makefile
# Verilator build and run for the stream buffer testbench.

VERILATOR ?= verilator
TOP       ?= stream_buffer_tb
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= ./obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	$(SIM) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
